/* sources.f */
+incdir+logic
logic/ex_pkg.sv
logic/ex_result_if.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage_top.sv
testbench/ex_stage_asserts.sv
testbench/ex_stage_tb.sv

/* testbench/ex_stage_tb.sv */
////////////////////////////////////////////////////////////
// Execute stage testbench
// Random stimulus, reference model and per-cycle compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                      clk;
  logic                      rst_n;
  ex_pkg::alu_op_e           alu_operator_i;
  logic [`EX_XLEN-1:0]       alu_operand_a_i;
  logic [`EX_XLEN-1:0]       alu_operand_b_i;
  logic [`EX_XLEN-1:0]       alu_operand_c_i;
  logic                      alu_en_i;
  ex_pkg::mult_op_e          mult_operator_i;
  logic [`EX_XLEN-1:0]       mult_operand_a_i;
  logic [`EX_XLEN-1:0]       mult_operand_b_i;
  logic                      mult_en_i;
  logic                      mult_multicycle_o;
  logic                      csr_access_i;
  logic [`EX_XLEN-1:0]       csr_rdata_i;
  logic                      lsu_en_i;
  logic [`EX_XLEN-1:0]       lsu_rdata_i;
  logic                      lsu_ready_ex_i;
  logic                      lsu_err_i;
  logic                      branch_in_ex_i;
  logic                      regfile_alu_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                      regfile_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i;
  logic                      regfile_alu_we_fw_o;
  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [`EX_XLEN-1:0]       regfile_alu_wdata_fw_o;
  logic                      regfile_we_wb_o;
  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic [`EX_XLEN-1:0]       regfile_wdata_wb_o;
  logic [`EX_XLEN-1:0]       jump_target_o;
  logic                      branch_decision_o;
  logic                      wb_ready_i;
  logic                      ex_ready_o;
  logic                      ex_valid_o;

  // Reference model state
  logic                      m_done;
  logic [`EX_XLEN-1:0]       m_high;
  logic                      wb_we;
  logic [`EX_REG_ADDR_W-1:0] wb_waddr;
  // Stage ready as the DUT showed it last cycle
  logic                      ready_seen;
  logic                      high_op;
  logic                      units_ok;
  logic                      exp_ready;
  logic                      exp_valid;
  logic [`EX_XLEN-1:0]       mult_res;
  logic [`EX_XLEN-1:0]       exp_fw;
  int                        cycle_count = 0;

  ex_stage_top UUT (.*);

  bind ex_stage_top ex_stage_asserts u_asserts (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid_i        (ex_valid_o),
    .ex_ready_i        (ex_ready_o),
    .wb_ready_i        (wb_ready_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .mult_multicycle_i (mult_multicycle_o),
    .regfile_we_wb_i   (regfile_we_wb_o)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////

  // One-bit outcome of compare ops and zero for the rest
  function automatic logic cmp_ref(ex_pkg::alu_op_e op, logic [`EX_XLEN-1:0] a,
                                   logic [`EX_XLEN-1:0] b);
    logic lt_s;
    logic lt_u;
    lt_u = a < b;
    // Flipping the sign bits turns signed order into unsigned order
    lt_s = (a ^ {1'b1, {(`EX_XLEN-1){1'b0}}}) < (b ^ {1'b1, {(`EX_XLEN-1){1'b0}}});
    case (op)
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   return lt_s;
      ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: return lt_u;
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_GE:  return !lt_s;
      ex_pkg::ALU_GEU: return !lt_u;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_ref(ex_pkg::alu_op_e op,
                                                  logic [`EX_XLEN-1:0] a,
                                                  logic [`EX_XLEN-1:0] b);
    logic [`EX_SHAMT_W-1:0] sh;
    logic [2*`EX_XLEN-1:0]  ext;
    sh  = b[`EX_SHAMT_W-1:0];
    ext = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    case (op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a - b;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_SLL: return a << sh;
      ex_pkg::ALU_SRL: return a >> sh;
      ex_pkg::ALU_SRA: begin
        // Sign-filled upper half shifts down into the word
        ext = ext >> sh;
        return ext[`EX_XLEN-1:0];
      end
      default: return {{(`EX_XLEN-1){1'b0}}, cmp_ref(op, a, b)};
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] mul_low_ref(logic [`EX_XLEN-1:0] a,
                                                      logic [`EX_XLEN-1:0] b);
    return a * b;
  endfunction

  // Upper word of the 64-bit product of the extended operands
  function automatic logic [`EX_XLEN-1:0] mul_high_ref(ex_pkg::mult_op_e op,
                                                       logic [`EX_XLEN-1:0] a,
                                                       logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    logic [2*`EX_XLEN-1:0] prod;
    ea = {{`EX_XLEN{1'b0}}, a};
    eb = {{`EX_XLEN{1'b0}}, b};
    if (op == ex_pkg::MULT_MULH || op == ex_pkg::MULT_MULHSU) begin
      ea = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    end
    if (op == ex_pkg::MULT_MULH) begin
      eb = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
    end
    prod = ea * eb;
    return prod[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  // Corner values mixed into the random operands
  function automatic logic [`EX_XLEN-1:0] pick_operand();
    case ($urandom % 8)
      0:       return {1'b1, {(`EX_XLEN-1){1'b0}}};
      1:       return '1;
      2:       return '0;
      default: return $urandom;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [`EX_XLEN-1:0] got,
                             input logic [`EX_XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // Bound checker failures
  always @(negedge clk) begin
    assert (UUT.u_asserts.fail_count == 0) else begin
      $display("bound assertion failed before %0t", $time);
      stop_with_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparing process on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      m_done     = 1'b0;
      m_high     = '0;
      wb_we      = 1'b0;
      wb_waddr   = '0;
      ready_seen = 1'b0;
      check_value("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
      check_value("mult_multicycle_o", mult_multicycle_o, 1'b0);
    end else begin
      high_op   = mult_en_i && (mult_operator_i != ex_pkg::MULT_MUL);
      mult_res  = m_done ? m_high : mul_low_ref(mult_operand_a_i, mult_operand_b_i);
      units_ok  = (m_done || !high_op) && lsu_ready_ex_i && wb_ready_i;
      exp_ready = units_ok || branch_in_ex_i;
      exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && units_ok;
      // CSR over multiplier over ALU
      if (csr_access_i) begin
        exp_fw = csr_rdata_i;
      end else if (mult_en_i) begin
        exp_fw = mult_res;
      end else if (alu_en_i) begin
        exp_fw = alu_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      end else begin
        exp_fw = '0;
      end
      check_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_fw);
      check_value("regfile_alu_we_fw_o", regfile_alu_we_fw_o, regfile_alu_we_i);
      check_value("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, regfile_alu_waddr_i);
      check_value("branch_decision_o", branch_decision_o,
                  alu_en_i && cmp_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i));
      check_value("jump_target_o", jump_target_o, alu_operand_c_i);
      check_value("ex_ready_o", ex_ready_o, exp_ready);
      check_value("ex_valid_o", ex_valid_o, exp_valid);
      check_value("mult_multicycle_o", mult_multicycle_o, m_done);
      check_value("regfile_we_wb_o", regfile_we_wb_o, wb_we);
      check_value("regfile_waddr_wb_o", regfile_waddr_wb_o, wb_waddr);
      check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
      // Next state of the multiplier
      if (m_done) begin
        if (exp_ready) begin
          m_done = 1'b0;
        end
      end else if (high_op) begin
        m_done = 1'b1;
        m_high = mul_high_ref(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
      end
      // Next state of the EX/WB register
      if (exp_valid) begin
        wb_we = regfile_we_i && !lsu_err_i;
        if (wb_we) begin
          wb_waddr = regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we = 1'b0;
      end
      ready_seen = ex_ready_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_inputs();
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_pkg::MULT_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  // Random ALU operands, write requests and load data
  task automatic randomize_alu();
    alu_operator_i      = ex_pkg::alu_op_e'($urandom % 16);
    alu_operand_a_i     = pick_operand();
    alu_operand_b_i     = ($urandom % 4 == 0) ? alu_operand_a_i : pick_operand();
    alu_operand_c_i     = $urandom;
    regfile_alu_we_i    = $urandom % 2;
    regfile_alu_waddr_i = $urandom;
    regfile_we_i        = $urandom % 2;
    regfile_waddr_i     = $urandom;
    lsu_err_i           = ($urandom % 4 == 0);
    lsu_rdata_i         = $urandom;
    csr_rdata_i         = $urandom;
  endtask

  // One multiply held until the stage reports ready
  task automatic issue_mult(input logic vary_wb);
    int stalls;
    randomize_alu();
    alu_en_i         = $urandom % 2;
    mult_en_i        = 1'b1;
    mult_operator_i  = ex_pkg::mult_op_e'($urandom % 4);
    mult_operand_a_i = pick_operand();
    mult_operand_b_i = pick_operand();
    wb_ready_i       = vary_wb ? ($urandom % 4 != 0) : 1'b1;
    stalls = 0;
    next_cycle();
    while (!ready_seen) begin
      stalls = stalls + 1;
      if (vary_wb) begin
        wb_ready_i = ($urandom % 4 != 0);
      end
      next_cycle();
    end
    if (!vary_wb) begin
      check_value("multiply stall cycles", stalls,
                  (mult_operator_i == ex_pkg::MULT_MUL) ? 0 : 1);
    end
  endtask

  initial begin
    void'($urandom(32'h9bbc));
    clk   = 1'b0;
    rst_n = 1'b0;
    clear_inputs();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // ALU results, comparisons and the EX/WB register on valid cycles
    repeat (200) begin
      randomize_alu();
      alu_en_i = 1'b1;
      next_cycle();
    end

    // Multiplies with WB always ready and then with back-pressure
    clear_inputs();
    repeat (60) issue_mult(1'b0);
    repeat (40) issue_mult(1'b1);

    // Forwarding priority with the single-cycle multiply only
    clear_inputs();
    repeat (40) begin
      randomize_alu();
      alu_en_i         = $urandom % 2;
      mult_en_i        = $urandom % 2;
      csr_access_i     = $urandom % 2;
      mult_operand_a_i = pick_operand();
      mult_operand_b_i = pick_operand();
      next_cycle();
    end

    // Load/store port with flush and hold
    clear_inputs();
    repeat (60) begin
      randomize_alu();
      lsu_en_i       = $urandom % 2;
      wb_ready_i     = $urandom % 2;
      lsu_ready_ex_i = ($urandom % 4 != 0);
      next_cycle();
    end

    // Stalls and branches forcing ready
    clear_inputs();
    repeat (40) begin
      randomize_alu();
      alu_operator_i = ex_pkg::alu_op_e'(8 + $urandom % 8);
      alu_en_i       = $urandom % 2;
      lsu_en_i       = $urandom % 2;
      branch_in_ex_i = $urandom % 2;
      wb_ready_i     = $urandom % 2;
      lsu_ready_ex_i = $urandom % 2;
      next_cycle();
    end

    clear_inputs();
    next_cycle();
    next_cycle();
    if (UUT.u_asserts.fail_count != 0) begin
      $display("bound assertions failed %0d times", UUT.u_asserts.fail_count);
      stop_with_failure();
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/ex_stage_asserts.sv */
////////////////////////////////////////////////////////////
// Execute stage protocol checks
// Bound into the stage top to watch handshake and reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_stage_asserts (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,
  input logic ex_ready_i,
  input logic wb_ready_i,
  input logic lsu_ready_ex_i,
  input logic mult_multicycle_i,
  input logic regfile_we_wb_i
);

  // Number of failed properties
  int fail_count = 0;

  // Completion only when both downstream units accept
  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> (wb_ready_i && lsu_ready_ex_i))
    else begin
      fail_count = fail_count + 1;
      $error("ex_valid_o high while WB or LSU not ready");
    end

  // Done state of the multiplier leaves once the stage moves on
  multicycle_clears: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_i && ex_ready_i) |=> !mult_multicycle_i)
    else begin
      fail_count = fail_count + 1;
      $error("mult_multicycle_o stayed high after ex_ready_o");
    end

  // No register write while in reset
  reset_no_write: assert property (@(posedge clk) !rst_n |-> !regfile_we_wb_i)
    else begin
      fail_count = fail_count + 1;
      $error("regfile_we_wb_o high during reset");
    end

endmodule

`default_nettype wire

/* logic/ex_stage_top.sv */
////////////////////////////////////////////////////////////
// Execute stage top
// ALU, multiplier and write-back joined by the result bundle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // ALU operands from ID/EX
  input  ex_pkg::alu_op_e           alu_operator_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_c_i,
  input  logic                      alu_en_i,
  // Multiplier operands
  input  ex_pkg::mult_op_e          mult_operator_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_b_i,
  input  logic                      mult_en_i,
  output logic                      mult_multicycle_o,
  // CSR and load/store
  input  logic                      csr_access_i,
  input  logic [`EX_XLEN-1:0]       csr_rdata_i,
  input  logic                      lsu_en_i,
  input  logic [`EX_XLEN-1:0]       lsu_rdata_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      lsu_err_i,
  // Register file write requests
  input  logic                      branch_in_ex_i,
  input  logic                      regfile_alu_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i,
  // Forwarding port to ID
  output logic                      regfile_alu_we_fw_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]       regfile_alu_wdata_fw_o,
  // Load/store port to WB
  output logic                      regfile_we_wb_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]       regfile_wdata_wb_o,
  // Branch outcome to IF
  output logic [`EX_XLEN-1:0]       jump_target_o,
  output logic                      branch_decision_o,
  // Stage handshake levels
  input  logic                      wb_ready_i,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  ex_result_if res_if ();

  // Target was computed in ID
  assign jump_target_o = alu_operand_c_i;

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .enable_i     (alu_en_i),
    .cmp_result_o (branch_decision_o),
    .res          (res_if.alu_mp)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .operand_a_i  (mult_operand_a_i),
    .operand_b_i  (mult_operand_b_i),
    .multicycle_o (mult_multicycle_o),
    .res          (res_if.mult_mp)
  );

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .res                    (res_if.wb_mp),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* logic/ex_writeback.sv */
////////////////////////////////////////////////////////////
// Execute output side
// Forwarding mux, EX/WB register and stall control
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_writeback (
  input  logic                      clk,
  input  logic                      rst_n,
  ex_result_if.wb_mp                res,
  input  logic                      alu_en_i,
  input  logic                      mult_en_i,
  input  logic                      csr_access_i,
  input  logic                      lsu_en_i,
  input  logic                      branch_in_ex_i,
  input  logic [`EX_XLEN-1:0]       csr_rdata_i,
  input  logic [`EX_XLEN-1:0]       lsu_rdata_i,
  input  logic                      regfile_alu_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      lsu_err_i,
  input  logic                      wb_ready_i,
  output logic                      regfile_alu_we_fw_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic                      regfile_we_wb_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]       regfile_wdata_wb_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic units_ready;
  logic lsu_we;

  ////////////////////////////////////////////////////////////
  // ALU write port, forwarded to ID and the register file
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR first, then multiplier, then ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register for the load/store port
  ////////////////////////////////////////////////////////////

  // A bus error cancels the write
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= lsu_we;
      if (lsu_we) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB took the last one and nothing new came, flush
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data goes straight through
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////////////////////////

  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX and never wait
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  assign res.ex_ready = ex_ready_o;

endmodule

`default_nettype wire

/* logic/ex_mult.sv */
////////////////////////////////////////////////////////////
// Integer multiplier
// Low word in one cycle, high words after a registered step
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  ex_pkg::mult_op_e     operator_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  output logic                 multicycle_o,
  ex_result_if.mult_mp         res
);

  logic                          sign_a;
  logic                          sign_b;
  logic [`EX_XLEN:0]             op_a_ext;
  logic [`EX_XLEN:0]             op_b_ext;
  logic signed [2*`EX_XLEN+1:0]  product;
  logic                          high_op;
  logic                          done_q;
  logic [`EX_XLEN-1:0]           high_q;

  ////////////////////////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////////////////////////

  // MULH signs both, MULHSU only A, MULHU neither
  assign sign_a = operand_a_i[`EX_XLEN-1] &
                  ((operator_i == ex_pkg::MULT_MULH) | (operator_i == ex_pkg::MULT_MULHSU));
  assign sign_b = operand_b_i[`EX_XLEN-1] & (operator_i == ex_pkg::MULT_MULH);

  assign op_a_ext = {sign_a, operand_a_i};
  assign op_b_ext = {sign_b, operand_b_i};

  // One signed multiplier covers all four ops, low word is the same for each
  assign product = $signed(op_a_ext) * $signed(op_b_ext);

  assign high_op = enable_i & (operator_i != ex_pkg::MULT_MUL);

  ////////////////////////////////////////////////////////////
  // Idle/done FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (done_q) begin
      // Hold the result until the stage moves on
      if (res.ex_ready) begin
        done_q <= 1'b0;
      end
    end else if (high_op) begin
      done_q <= 1'b1;
    end
  end

  // Upper half captured at the issue edge
  always_ff @(posedge clk) begin
    if (!done_q && high_op) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  // Issue cycle of a high op is the only stall
  assign res.mult_ready  = done_q | ~high_op;
  assign res.mult_result = done_q ? high_q : product[`EX_XLEN-1:0];
  assign multicycle_o    = done_q;

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
////////////////////////////////////////////////////////////
// Integer ALU
// Arithmetic, logic, shifts and the comparison for branches
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_alu (
  input  ex_pkg::alu_op_e      operator_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  input  logic                 enable_i,
  output logic                 cmp_result_o,
  ex_result_if.alu_mp          res
);

  logic [`EX_SHAMT_W-1:0] shamt;
  logic                   lt_s;
  logic                   lt_u;
  logic                   eq;
  logic                   is_cmp;
  logic                   cmp_bit;
  logic [`EX_XLEN-1:0]    result;

  // Shifts only look at the low bits of B
  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  // Shared comparators for SLT and branches
  assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u = operand_a_i < operand_b_i;
  assign eq   = operand_a_i == operand_b_i;

  ////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result  = '0;
    cmp_bit = 1'b0;
    is_cmp  = 1'b0;
    case (operator_i)
      ex_pkg::ALU_ADD: result = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: result = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: result = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA: result = $signed(operand_a_i) >>> shamt;
      // Set-less-than and the six branch tests
      ex_pkg::ALU_SLT:  {is_cmp, cmp_bit} = {1'b1, lt_s};
      ex_pkg::ALU_SLTU: {is_cmp, cmp_bit} = {1'b1, lt_u};
      ex_pkg::ALU_EQ:   {is_cmp, cmp_bit} = {1'b1, eq};
      ex_pkg::ALU_NE:   {is_cmp, cmp_bit} = {1'b1, ~eq};
      ex_pkg::ALU_LT:   {is_cmp, cmp_bit} = {1'b1, lt_s};
      ex_pkg::ALU_GE:   {is_cmp, cmp_bit} = {1'b1, ~lt_s};
      ex_pkg::ALU_LTU:  {is_cmp, cmp_bit} = {1'b1, lt_u};
      ex_pkg::ALU_GEU:  {is_cmp, cmp_bit} = {1'b1, ~lt_u};
      default: result = '0;
    endcase
    // Compare result goes out zero-extended
    if (is_cmp) begin
      result = {{(`EX_XLEN-1){1'b0}}, cmp_bit};
    end
  end

  assign res.alu_result = result;

  // No branch seen when the ALU is idle
  assign cmp_result_o = enable_i & is_cmp & cmp_bit;

endmodule

`default_nettype wire

/* logic/ex_result_if.sv */
////////////////////////////////////////////////////////////
// Execute result bundle
// Unit results toward write-back, stage ready back to units
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

interface ex_result_if;

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  // Multiplier can accept or finish this cycle
  logic                mult_ready;
  // Whole stage ready, returned to the multiplier FSM
  logic                ex_ready;

  modport alu_mp  (output alu_result);
  modport mult_mp (output mult_result, output mult_ready, input ex_ready);
  modport wb_mp   (input alu_result, input mult_result, input mult_ready, output ex_ready);

endinterface

`default_nettype wire

/* logic/ex_pkg.sv */
////////////////////////////////////////////////////////////
// Execute stage types
// Operation encodings for the ALU and the multiplier
////////////////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

  // ALU operations, the last eight produce a one-bit result
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operations, only MUL is single cycle
  typedef enum logic [1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

endpackage

`default_nettype wire

/* logic/ex_params.svh */
////////////////////////////////////////////////////////////
// Execute stage widths
// Data word, register address and shift amount sizes
////////////////////////////////////////////////////////////

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width, covers integer and spare regs
`define EX_REG_ADDR_W 6

// Shift amount, low bits of operand B only
`define EX_SHAMT_W 5

`endif
